//--- Makefile
# Verilator build and run for the reorder bank testbench
# Any variable can be overridden on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_llbank
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert
PASS_MSG  ?= PASS: all tests

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv test/*.sv test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
+incdir+test
source/llbank_pkg.sv
source/slot_ram.sv
source/free_slot_finder.sv
source/release_arbiter.sv
source/linkedlist_ctrl.sv
source/llbank_top.sv
test/tb_llbank.sv

//--- source/free_slot_finder.sv
////////////////////
// Slot occupancy tracking for the bank
// Set and clear must target different slots in one cycle
// Free slot output is meaningless while full is high
////////////////////

module free_slot_finder (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Allocation of a slot on input
  input  logic                             i_set,
  input  logic [llbank_pkg::SlotWidth-1:0] i_set_slot,

  // Release of a slot on output
  input  logic                             i_clear,
  input  logic [llbank_pkg::SlotWidth-1:0] i_clear_slot,

  // Search results
  output logic [llbank_pkg::SlotWidth-1:0] o_free_slot,
  output logic                             o_full
);

  import llbank_pkg::*;

  // One bit per slot, high when the slot holds a message
  logic [Capacity-1:0] occ_q;
  logic [Capacity-1:0] occ_d;

  ////////////////////
  // Occupancy update
  ////////////////////

  always_comb begin
    occ_d = occ_q;
    if (i_set) begin
      occ_d[i_set_slot] = 1'b1;
    end
    if (i_clear) begin
      occ_d[i_clear_slot] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

  ////////////////////
  // Lowest free slot
  ////////////////////

  // Scan downwards so the lowest free index wins
  always_comb begin
    o_free_slot = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        o_free_slot = SlotWidth'(i);
      end
    end
  end

  // Full when every slot is taken
  assign o_full = &occ_q;

  // Controller only allocates slots reported free here
  a_set_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    i_set |-> !occ_q[i_set_slot]);

endmodule

//--- source/linkedlist_ctrl.sv
////////////////////
// Per-identifier linked-list pointers and handshake decisions
// Head is the newest slot, oldest is the next to release
// Link memory read must be combinational at o_link_rd_slot
////////////////////

module linkedlist_ctrl (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,

  // Input side
  input  logic                                                     i_in_valid,
  input  llbank_pkg::msg_t                                         i_in_msg,
  output logic                                                     o_in_ready,

  // Free slot search
  input  logic [llbank_pkg::SlotWidth-1:0]                         i_free_slot,
  input  logic                                                     i_full,

  // Message memory write
  output logic                                                     o_alloc,
  output logic [llbank_pkg::SlotWidth-1:0]                         o_alloc_slot,
  output logic [llbank_pkg::ContentWidth-1:0]                      o_msg_wr_content,

  // Link memory access
  output llbank_pkg::link_wr_t                                     o_link_wr,
  input  logic [llbank_pkg::SlotWidth-1:0]                         i_link_nxt,
  output logic [llbank_pkg::SlotWidth-1:0]                         o_link_rd_slot,

  // Arbiter interface
  input  llbank_pkg::release_t                                     i_release,
  output logic [llbank_pkg::NumIds-1:0]                            o_nonempty,
  output logic [llbank_pkg::NumIds-1:0][llbank_pkg::SlotWidth-1:0] o_oldest_slots,

  // Slot release
  output logic                                                     o_free,
  output logic [llbank_pkg::SlotWidth-1:0]                         o_free_slot
);

  import llbank_pkg::*;

  ////////////////////
  // Queue state
  ////////////////////

  // Newest slot of each queue
  logic [SlotWidth-1:0] head_q   [NumIds];
  logic [SlotWidth-1:0] head_d   [NumIds];
  // Next slot to release of each queue
  logic [SlotWidth-1:0] oldest_q [NumIds];
  logic [SlotWidth-1:0] oldest_d [NumIds];
  // Number of stored messages per queue
  logic [LenWidth-1:0]  len_q    [NumIds];
  logic [LenWidth-1:0]  len_d    [NumIds];

  // Input handshake and its queue
  logic                 in_fire;
  logic [IdWidth-1:0]   in_id;
  logic                 rel_on_in_id;
  logic [LenWidth-1:0]  in_len_after_rel;

  ////////////////////
  // Input handshake
  ////////////////////

  // Ready only from occupancy
  assign o_in_ready = !i_full;
  assign in_fire    = i_in_valid && o_in_ready;
  assign in_id      = i_in_msg.id;

  // Store content at the lowest free slot
  assign o_alloc          = in_fire;
  assign o_alloc_slot     = i_free_slot;
  assign o_msg_wr_content = i_in_msg.content;

  // Length of the input queue once a same-cycle release is applied
  assign rel_on_in_id     = i_release.valid && (i_release.id == in_id);
  assign in_len_after_rel = len_q[in_id] - LenWidth'(rel_on_in_id);

  // Chain the new slot behind the current head
  // Not when the queue empties this cycle, the new slot becomes oldest instead
  assign o_link_wr.en   = in_fire && (in_len_after_rel != '0);
  assign o_link_wr.slot = head_q[in_id];
  assign o_link_wr.nxt  = i_free_slot;

  ////////////////////
  // Release side
  ////////////////////

  // Successor of the slot being released
  assign o_link_rd_slot = oldest_q[i_release.id];

  // Slot goes free as its message moves to the output register
  assign o_free      = i_release.valid;
  assign o_free_slot = i_release.slot;

  ////////////////////
  // Per-identifier update
  ////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_queue
    logic                in_hit;
    logic                rel_hit;
    logic [LenWidth-1:0] len_after_rel;

    assign in_hit        = in_fire && (in_id == IdWidth'(g));
    assign rel_hit       = i_release.valid && (i_release.id == IdWidth'(g));
    assign len_after_rel = len_q[g] - LenWidth'(rel_hit);

    // Release and input on one queue merge into a single update
    always_comb begin
      len_d[g]    = len_after_rel + LenWidth'(in_hit);
      head_d[g]   = in_hit ? i_free_slot : head_q[g];
      oldest_d[g] = oldest_q[g];
      // Advance along the list
      if (rel_hit) begin
        oldest_d[g] = i_link_nxt;
      end
      // Empty queue starts at the new slot
      if (in_hit && (len_after_rel == '0)) begin
        oldest_d[g] = i_free_slot;
      end
    end

    // Status towards the arbiter
    assign o_nonempty[g]     = (len_q[g] != '0);
    assign o_oldest_slots[g] = oldest_q[g];

    // Queue cannot outgrow the slot memory
    a_len_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      len_q[g] <= LenWidth'(Capacity));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q   <= '{default: '0};
      oldest_q <= '{default: '0};
      len_q    <= '{default: '0};
    end else begin
      head_q   <= head_d;
      oldest_q <= oldest_d;
      len_q    <= len_d;
    end
  end

endmodule

//--- source/llbank_pkg.sv
////////////////////
// Sizes and types shared by the reorder bank
// NumIds must equal 2**IdWidth and Capacity must equal 2**SlotWidth
// LenWidth must hold the value Capacity
////////////////////

package llbank_pkg;

  // Bank dimensions
  localparam int unsigned NumIds       = 4;
  localparam int unsigned IdWidth      = 2;
  localparam int unsigned Capacity     = 16;
  localparam int unsigned SlotWidth    = 4;
  localparam int unsigned ContentWidth = 8;
  // Queue length counter, one bit wider than a slot address
  localparam int unsigned LenWidth     = SlotWidth + 1;

  // Write response as seen on both sides of the bank
  typedef struct packed {
    logic [IdWidth-1:0]      id;
    logic [ContentWidth-1:0] content;
  } msg_t;

  // Write port of the link memory
  typedef struct packed {
    logic                 en;
    logic [SlotWidth-1:0] slot;
    logic [SlotWidth-1:0] nxt;
  } link_wr_t;

  // Release decision from the arbiter
  typedef struct packed {
    logic                 valid;
    logic [IdWidth-1:0]   id;
    logic [SlotWidth-1:0] slot;
  } release_t;

endpackage

//--- source/llbank_top.sv
////////////////////
// Linked-list reorder bank for write responses
// Lowest nonempty identifier is served first, order kept per identifier
// Holds up to Capacity messages plus one in the output register
////////////////////

module llbank_top (
  input  logic             clk_i,
  input  logic             rst_ni,

  // Input side
  input  logic             i_in_valid,
  input  llbank_pkg::msg_t i_in_msg,
  output logic             o_in_ready,

  // Output side
  output logic             o_out_valid,
  output llbank_pkg::msg_t o_out_msg,
  input  logic             i_out_ready
);

  import llbank_pkg::*;

  ////////////////////
  // Internal wires
  ////////////////////

  // Slot allocation
  logic [SlotWidth-1:0]                 free_slot;
  logic                                 full;
  logic                                 alloc;
  logic [SlotWidth-1:0]                 alloc_slot;
  logic [ContentWidth-1:0]              msg_wr_content;
  // Slot release
  logic                                 free;
  logic [SlotWidth-1:0]                 free_slot_rel;
  // Link memory
  link_wr_t                             link_wr;
  logic [SlotWidth-1:0]                 link_nxt;
  logic [SlotWidth-1:0]                 link_rd_slot;
  // Arbitration
  release_t                             rel;
  logic [NumIds-1:0]                    nonempty;
  logic [NumIds-1:0][SlotWidth-1:0]     oldest_slots;
  logic [ContentWidth-1:0]              rd_content;

  linkedlist_ctrl u_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .i_in_valid       (i_in_valid),
    .i_in_msg         (i_in_msg),
    .o_in_ready       (o_in_ready),
    .i_free_slot      (free_slot),
    .i_full           (full),
    .o_alloc          (alloc),
    .o_alloc_slot     (alloc_slot),
    .o_msg_wr_content (msg_wr_content),
    .o_link_wr        (link_wr),
    .i_link_nxt       (link_nxt),
    .o_link_rd_slot   (link_rd_slot),
    .i_release        (rel),
    .o_nonempty       (nonempty),
    .o_oldest_slots   (oldest_slots),
    .o_free           (free),
    .o_free_slot      (free_slot_rel)
  );

  free_slot_finder u_finder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_set        (alloc),
    .i_set_slot   (alloc_slot),
    .i_clear      (free),
    .i_clear_slot (free_slot_rel),
    .o_free_slot  (free_slot),
    .o_full       (full)
  );

  release_arbiter u_arbiter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .i_nonempty     (nonempty),
    .i_oldest_slots (oldest_slots),
    .i_content      (rd_content),
    .i_out_ready    (i_out_ready),
    .o_release      (rel),
    .o_out_valid    (o_out_valid),
    .o_out_msg      (o_out_msg)
  );

  // Message contents, read at the released slot
  slot_ram #(
    .Width (ContentWidth),
    .Depth (Capacity)
  ) u_msg_ram (
    .clk_i     (clk_i),
    .i_wr_en   (alloc),
    .i_wr_addr (alloc_slot),
    .i_wr_data (msg_wr_content),
    .i_rd_addr (rel.slot),
    .o_rd_data (rd_content)
  );

  // Next-slot links, read at the oldest slot of the released queue
  slot_ram #(
    .Width (SlotWidth),
    .Depth (Capacity)
  ) u_link_ram (
    .clk_i     (clk_i),
    .i_wr_en   (link_wr.en),
    .i_wr_addr (link_wr.slot),
    .i_wr_data (link_wr.nxt),
    .i_rd_addr (link_rd_slot),
    .o_rd_data (link_nxt)
  );

endmodule

//--- source/release_arbiter.sv
////////////////////
// Picks the lowest nonempty identifier and holds the output message
// Content must be read combinationally at the released slot
// Output stays stable until accepted
////////////////////

module release_arbiter (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,

  // Queue state from the controller
  input  logic [llbank_pkg::NumIds-1:0]                           i_nonempty,
  input  logic [llbank_pkg::NumIds-1:0][llbank_pkg::SlotWidth-1:0] i_oldest_slots,

  // Message content at the released slot
  input  logic [llbank_pkg::ContentWidth-1:0]                     i_content,

  // Output side
  input  logic                                                    i_out_ready,
  output llbank_pkg::release_t                                    o_release,
  output logic                                                    o_out_valid,
  output llbank_pkg::msg_t                                        o_out_msg
);

  import llbank_pkg::*;

  logic              load_en;
  logic [NumIds-1:0] sel_onehot;
  logic              out_valid_q;
  msg_t              out_msg_q;

  // Register empty or draining this cycle
  assign load_en = !out_valid_q || i_out_ready;

  // Isolate the lowest set bit
  assign sel_onehot = i_nonempty & (~i_nonempty + NumIds'(1));

  ////////////////////
  // Release decision
  ////////////////////

  // One-hot mux of identifier and oldest slot
  always_comb begin
    o_release       = '0;
    o_release.valid = load_en && |i_nonempty;
    for (int i = 0; i < NumIds; i++) begin
      o_release.id   = o_release.id | ({IdWidth{sel_onehot[i]}} & IdWidth'(i));
      o_release.slot = o_release.slot | ({SlotWidth{sel_onehot[i]}} & i_oldest_slots[i]);
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (load_en) begin
      out_valid_q <= o_release.valid;
    end
  end

  // Release valid already implies load_en
  always_ff @(posedge clk_i) begin
    if (o_release.valid) begin
      out_msg_q <= '{id: o_release.id, content: i_content};
    end
  end

  assign o_out_valid = out_valid_q;
  assign o_out_msg   = out_msg_q;

  // Stalled output keeps valid and payload
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_msg));

endmodule

//--- source/slot_ram.sv
////////////////////
// Register-array slot memory, one write and one read port
// Write lands at the clock edge, read is combinational
// Depth is expected to be a power of two, contents are undefined after reset
////////////////////

module slot_ram #(
  parameter int unsigned Width = 8,
  parameter int unsigned Depth = 16
) (
  input  logic                     clk_i,

  // Write port
  input  logic                     i_wr_en,
  input  logic [$clog2(Depth)-1:0] i_wr_addr,
  input  logic [Width-1:0]         i_wr_data,

  // Read port
  input  logic [$clog2(Depth)-1:0] i_rd_addr,
  output logic [Width-1:0]         o_rd_data
);

  // Storage array
  logic [Width-1:0] mem_q [Depth];

  ////////////////////
  // Write
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem_q[i_wr_addr] <= i_wr_data;
    end
  end

  ////////////////////
  // Read
  ////////////////////

  // Asynchronous read, sees a write only after its edge
  assign o_rd_data = mem_q[i_rd_addr];

endmodule

//--- test/tb_llbank_model.svh
////////////////////
// Reference model of the bank, one queue of contents per identifier
// Must be included inside a module that imports llbank_pkg
////////////////////

`ifndef TB_LLBANK_MODEL_SVH
`define TB_LLBANK_MODEL_SVH

// Contents of accepted messages not yet seen at the output, oldest first
logic [ContentWidth-1:0] pending_q [NumIds][$];

// Record an accepted input at the back of its queue
task automatic push_sent(input msg_t m);
  pending_q[m.id].push_back(m.content);
endtask

// Identifier still has stored messages
function automatic bit has_pending(input logic [IdWidth-1:0] id);
  return pending_q[id].size() != 0;
endfunction

// Expected output for this identifier
// Same-identifier order is arrival order, so it is the front entry
function automatic msg_t expected_msg(input logic [IdWidth-1:0] id);
  msg_t m;
  m.id      = id;
  m.content = pending_q[id][0];
  return m;
endfunction

// Remove the front entry once its output has been checked
task automatic pop_received(input logic [IdWidth-1:0] id);
  void'(pending_q[id].pop_front());
endtask

// Lowest identifier that still has messages
// Minus one when every queue is empty
function automatic int lowest_pending_id();
  int low;
  low = -1;
  for (int i = 0; i < NumIds; i++) begin
    if (low < 0 && pending_q[i].size() != 0) begin
      low = i;
    end
  end
  return low;
endfunction

// Messages held by the model over all identifiers
function automatic int pending_total();
  int total;
  total = 0;
  for (int i = 0; i < NumIds; i++) begin
    total += pending_q[i].size();
  end
  return total;
endfunction

`endif

//--- test/tb_llbank.sv
////////////////////
// Testbench for llbank_top against a per-identifier reference model
// Random traffic, full drain, fill under back-pressure, priority drain
// Run is bounded by a cycle counter
////////////////////

module tb_llbank;

  import llbank_pkg::*;

  // Test length and limits
  localparam int NumMsgs       = 200;
  localparam int Seed          = 30;
  localparam int TimeoutCycles = (NumMsgs + int'(Capacity) + 1) * 20;

  logic clk_i;
  logic rst_ni;
  logic in_valid;
  msg_t in_msg;
  logic in_ready;
  logic out_valid;
  msg_t out_msg;
  logic out_ready;

  int   seed;
  // Monitor state
  int   sent_count = 0;
  int   recv_count = 0;
  int   mon_errors = 0;
  int   prio_outs  = 0;
  bit   held_valid = 1'b0;
  msg_t held_msg;
  // Stimulus state
  int   stim_errors = 0;
  bit   prio_armed;
  bit   timed_out = 1'b0;
  int   cycle_count;

  `include "tb_llbank_model.svh"

  llbank_top llbank_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .i_in_valid  (in_valid),
    .i_in_msg    (in_msg),
    .o_in_ready  (in_ready),
    .o_out_valid (out_valid),
    .o_out_msg   (out_msg),
    .i_out_ready (out_ready)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic msg_t random_msg();
    logic [31:0] r;
    msg_t        m;
    r         = $random(seed);
    m.id      = r[IdWidth-1:0];
    m.content = r[ContentWidth+7:8];
    return m;
  endfunction

  task automatic check_value(input int got, input int exp, input string what);
    assert (got == exp) else begin
      stim_errors++;
      $display("Mismatch at %0t: %s, expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  // Compare one output transfer with the model, then pop it
  task automatic check_output(input msg_t got);
    msg_t exp;
    int   low;
    low = lowest_pending_id();
    recv_count++;
    assert (has_pending(got.id)) else begin
      mon_errors++;
      $display("Output with id %0d at %0t has no pending message in the model",
               got.id, $time);
    end
    if (has_pending(got.id)) begin
      exp = expected_msg(got.id);
      assert (got == exp) else begin
        mon_errors++;
        $display("Mismatch at %0t: output expected %h got %h", $time, exp, got);
      end
      // First output of the priority drain was loaded before ready rose
      if (prio_armed) begin
        if (prio_outs > 0) begin
          assert (int'(got.id) == low) else begin
            mon_errors++;
            $display("Mismatch at %0t: priority id expected %0d got %0d",
                     $time, low, got.id);
          end
        end
        prio_outs++;
      end
      pop_received(got.id);
    end
  endtask

  ////////////////////
  // Comparison process
  ////////////////////

  // Both handshakes sampled at the rising edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (in_valid && in_ready) begin
        push_sent(in_msg);
        sent_count++;
      end
      // Stalled output keeps valid and payload
      if (held_valid) begin
        assert (out_valid && out_msg == held_msg) else begin
          mon_errors++;
          $display("Mismatch at %0t: stalled output expected %h got %h",
                   $time, held_msg, out_msg);
        end
      end
      if (out_valid && out_ready) begin
        check_output(out_msg);
      end
      held_valid = out_valid && !out_ready;
      held_msg   = out_msg;
    end
  end

  ////////////////////
  // Stimulus phases
  ////////////////////

  // Random valid, identifier, content and output ready
  task automatic run_random_traffic(input int count);
    int          accepted;
    logic [31:0] r;
    accepted = 0;
    while (accepted < count) begin
      @(posedge clk_i);
      if (in_valid && in_ready) begin
        accepted++;
      end
      r = $random(seed);
      // An offered input stays until it is taken
      if (!in_valid || in_ready) begin
        in_valid <= (r[1:0] != 2'b00) && (accepted < count);
        in_msg   <= random_msg();
      end
      out_ready <= r[2];
    end
  endtask

  // Hold output ready low and offer inputs until ready stays low
  task automatic fill_under_backpressure();
    int accepted;
    int stalls;
    accepted = 0;
    stalls   = 0;
    @(posedge clk_i);
    out_ready <= 1'b0;
    in_valid  <= 1'b1;
    in_msg    <= random_msg();
    while (stalls < 8) begin
      @(posedge clk_i);
      if (in_ready) begin
        accepted++;
        stalls = 0;
        in_msg <= random_msg();
      end else begin
        stalls++;
      end
    end
    in_valid <= 1'b0;
    // Slots plus the output register
    check_value(accepted, int'(Capacity) + 1, "messages accepted under back-pressure");
  endtask

  // Stop inputs, accept every output, wait until the model is empty
  task automatic drain_all(input bit by_priority);
    @(posedge clk_i);
    in_valid   <= 1'b0;
    out_ready  <= 1'b1;
    prio_armed <= by_priority;
    while (recv_count != sent_count) begin
      @(negedge clk_i);
    end
    check_value(pending_total(), 0, "messages left in the model after drain");
    check_value(int'(out_valid), 0, "output valid once all messages came out");
  endtask

  task automatic finish_run();
    int total;
    total = mon_errors + stim_errors + int'(timed_out);
    $display("Summary: %0d errors, %0d messages sent, %0d received",
             total, sent_count, recv_count);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    seed       = Seed;
    rst_ni     = 1'b0;
    in_valid   = 1'b0;
    in_msg     = '0;
    out_ready  = 1'b0;
    prio_armed = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value(int'(out_valid), 0, "output valid after reset");
    check_value(int'(in_ready), 1, "input ready after reset");
    run_random_traffic(NumMsgs);
    drain_all(1'b0);
    fill_under_backpressure();
    drain_all(1'b1);
    check_value(prio_outs, int'(Capacity) + 1, "outputs in the priority drain");
    finish_run();
  end

  // Cycle limit from the message count
  initial begin
    cycle_count = 0;
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    timed_out = 1'b1;
    $display("Timeout after %0d cycles, the test did not finish", cycle_count);
    finish_run();
  end

endmodule
